//--- scene_pkg.sv
`default_nettype none

package scene_pkg;

  // Camera vector as sent by the host: x in the top bits, z in the low bits
  typedef struct packed {
    logic signed [23:0] x;
    logic signed [23:0] y;
    logic signed [23:0] z;
  } cam_vec_t;

  // Sphere record, 64 bits total
  typedef struct packed {
    logic [15:0] cx;
    logic [15:0] cy;
    logic [15:0] cz;
    logic [7:0]  radius;
    logic [7:0]  color;
  } scene_obj_t;

  // Camera vector select, taken from command bits 1:0
  typedef enum logic [1:0] {
    CAM_ORIGIN  = 2'd0,
    CAM_RIGHT   = 2'd1,
    CAM_FORWARD = 2'd2,
    CAM_UP      = 2'd3
  } cam_sel_e;

  typedef enum logic [1:0] {
    IDLE,
    DATA_CAM,
    DATA_OBJ
  } parse_state_e;

  localparam int CAM_BYTES = $bits(cam_vec_t) / 8;   // 9
  localparam int OBJ_BYTES = $bits(scene_obj_t) / 8; // 8

endpackage

`default_nettype wire

//--- scene_wr_if.sv
`timescale 1ns/10ps
`default_nettype none

// One finished frame from the parser, seen by both stores at once
interface scene_wr_if;
  import scene_pkg::*;

  logic [7:0] cmd;
  cam_vec_t   cam_data;
  scene_obj_t obj_data;
  logic       wen;      // Single-cycle write strobe

  modport source (output cmd, output cam_data, output obj_data, output wen);
  modport sink (input cmd, input cam_data, input obj_data, input wen);

endinterface

`default_nettype wire

//--- uart_byte_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_byte_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int HALF_BIT = CLKS_PER_BIT / 2;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e state;
  logic rx_meta;
  logic rx_sync;
  logic rx_prev;                // For start edge detection
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0] bit_idx;
  logic [7:0] shift;

  // Line idles high, so the synchronizer resets to one
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (rx_prev && !rx_sync) state <= RX_START; // Falling edge
        end
        RX_START: begin
          if (clk_cnt == CNT_W'(HALF_BIT - 1)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // Glitch shorter than half a bit goes back to idle
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            shift   <= {rx_sync, shift[7:1]};  // LSB first
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            state   <= RX_IDLE;
            if (rx_sync) begin              // Bad stop bit drops the byte
              rx_valid <= 1'b1;
              rx_byte  <= shift;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  a_valid_single: assert property (@(posedge clk) disable iff (rst)
    rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

//--- scene_cmd_parser.sv
`timescale 1ns/10ps
`default_nettype none

module scene_cmd_parser (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx_valid,
  input  logic [7:0] rx_byte,
  output logic       load_busy,
  scene_wr_if.source wr
);
  import scene_pkg::*;

  /*
    Frame layout
      cmd 1xxxxxSS  camera vector SS, then 9 payload bytes
      cmd 0iiiiiii  object index i, then 8 payload bytes
    Payload goes least significant byte first
  */

  localparam int CNT_W = $clog2(CAM_BYTES);

  parse_state_e state;
  logic [CNT_W-1:0] byte_cnt;
  logic [7:0] cmd_q;
  cam_vec_t cam_shift;
  scene_obj_t obj_shift;
  logic wen_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      byte_cnt  <= '0;
      load_busy <= 1'b0;
      wen_q     <= 1'b0;
    end else begin
      wen_q <= 1'b0;
      case (state)
        IDLE: begin
          if (wen_q) load_busy <= 1'b0;  // Drops the cycle after the write
          if (rx_valid) begin
            cmd_q     <= rx_byte;
            byte_cnt  <= '0;
            load_busy <= 1'b1;
            state     <= rx_byte[7] ? DATA_CAM : DATA_OBJ;
          end
        end
        DATA_CAM: begin
          if (rx_valid) begin
            // New byte enters at the top, first byte ends up lowest
            cam_shift <= {rx_byte, cam_shift[$bits(cam_vec_t)-1:8]};
            if (byte_cnt == CNT_W'(CAM_BYTES - 1)) begin
              wen_q <= 1'b1;
              state <= IDLE;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end
        DATA_OBJ: begin
          if (rx_valid) begin
            obj_shift <= {rx_byte, obj_shift[$bits(scene_obj_t)-1:8]};
            if (byte_cnt == CNT_W'(OBJ_BYTES - 1)) begin
              wen_q <= 1'b1;
              state <= IDLE;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign wr.cmd      = cmd_q;
  assign wr.cam_data = cam_shift;
  assign wr.obj_data = obj_shift;
  assign wr.wen      = wen_q;

  a_wen_after_data: assert property (@(posedge clk) disable iff (rst)
    wen_q |-> (state == IDLE) && ($past(state) inside {DATA_CAM, DATA_OBJ}));

endmodule

`default_nettype wire

//--- camera_regs.sv
`timescale 1ns/10ps
`default_nettype none

module camera_regs (
  input  logic              clk,
  input  logic              rst,
  scene_wr_if.sink          wr,
  output scene_pkg::cam_vec_t cam [4]
);
  import scene_pkg::*;

  cam_sel_e sel;
  logic cam_wen;

  assign sel     = cam_sel_e'(wr.cmd[1:0]);
  assign cam_wen = wr.wen && wr.cmd[7];   // Camera frames only

  // Renderer expects a zeroed camera until the host loads one
  always_ff @(posedge clk) begin
    if (rst) begin
      foreach (cam[i]) begin
        cam[i] <= '0;
      end
    end else if (cam_wen) begin
      cam[sel] <= wr.cam_data;
    end
  end

endmodule

`default_nettype wire

//--- object_ram.sv
`timescale 1ns/10ps
`default_nettype none

module object_ram #(
  parameter int NUM_OBJS = 8
) (
  input  logic                        clk,
  input  logic                        rst,
  scene_wr_if.sink                    wr,
  input  logic [$clog2(NUM_OBJS)-1:0] rd_idx,
  output scene_pkg::scene_obj_t       rd_obj
);
  import scene_pkg::*;

  localparam int IDX_W = $clog2(NUM_OBJS);

  scene_obj_t mem [NUM_OBJS];
  logic [IDX_W-1:0] wr_idx;
  logic obj_wen;

  // Index bits beyond the table size are ignored, so slots wrap
  assign wr_idx  = wr.cmd[IDX_W-1:0];
  assign obj_wen = wr.wen && !wr.cmd[7];

  // Flop array, every slot must read zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      foreach (mem[i]) begin
        mem[i] <= '0;
      end
    end else if (obj_wen) begin
      mem[wr_idx] <= wr.obj_data;
    end
  end

  assign rd_obj = mem[rd_idx];   // Async read

endmodule

`default_nettype wire

//--- scene_wb_port.sv
`timescale 1ns/10ps
`default_nettype none

module scene_wb_port #(
  parameter int NUM_OBJS = 8
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [6:0]                  wb_adr,
  output logic [31:0]                 wb_dat_o,
  output logic                        wb_ack,
  input  scene_pkg::cam_vec_t         cam [4],
  output logic [$clog2(NUM_OBJS)-1:0] rd_idx,
  input  scene_pkg::scene_obj_t       rd_obj
);
  import scene_pkg::*;

  localparam int IDX_W = $clog2(NUM_OBJS);

  /*
    Word map
      adr[6] = 0  camera, adr[3:2] vector, adr[1:0] word (0 low, 1 mid, 2 top byte)
      adr[6] = 1  object, adr[5:1] index, adr[0] high word
  */

  cam_sel_e vec_sel;
  cam_vec_t vec;
  logic [31:0] cam_word;
  logic [31:0] obj_word;
  logic [31:0] rd_data;
  logic req;

  assign vec_sel = cam_sel_e'(wb_adr[3:2]);
  assign vec     = cam[vec_sel];
  assign rd_idx  = IDX_W'(wb_adr[5:1]);

  always_comb begin
    case (wb_adr[1:0])
      2'd0:    cam_word = vec[31:0];
      2'd1:    cam_word = vec[63:32];
      2'd2:    cam_word = {24'd0, vec[71:64]};
      default: cam_word = '0;            // Unused slot
    endcase
  end

  assign obj_word = wb_adr[0] ? rd_obj[63:32] : rd_obj[31:0];
  assign rd_data  = wb_adr[6] ? obj_word : cam_word;

  // New request only when no ack is out, so each strobe gets one ack
  assign req = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) wb_dat_o <= wb_we ? '0 : rd_data;  // Writes are read-only no-ops
  end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

//--- scene_loader_top.sv
`timescale 1ns/10ps
`default_nettype none

module scene_loader_top #(
  parameter int CLKS_PER_BIT = 16,
  parameter int NUM_OBJS     = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        uart_rx,
  output logic        load_busy,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [6:0]  wb_adr,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack
);
  import scene_pkg::*;

  localparam int IDX_W = $clog2(NUM_OBJS);

  logic rx_valid;
  logic [7:0] rx_byte;
  cam_vec_t cam_vecs [4];
  logic [IDX_W-1:0] obj_rd_idx;
  scene_obj_t obj_rd_data;

  scene_wr_if wr_bus ();   // Parser to both stores

  uart_byte_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_rx (
    .clk      (clk),
    .rst      (rst),
    .rx       (uart_rx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  scene_cmd_parser u_parser (
    .clk       (clk),
    .rst       (rst),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .load_busy (load_busy),
    .wr        (wr_bus.source)
  );

  camera_regs u_cam (
    .clk (clk),
    .rst (rst),
    .wr  (wr_bus.sink),
    .cam (cam_vecs)
  );

  object_ram #(
    .NUM_OBJS(NUM_OBJS)
  ) u_objs (
    .clk    (clk),
    .rst    (rst),
    .wr     (wr_bus.sink),
    .rd_idx (obj_rd_idx),
    .rd_obj (obj_rd_data)
  );

  scene_wb_port #(
    .NUM_OBJS(NUM_OBJS)
  ) u_wb (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .cam      (cam_vecs),
    .rd_idx   (obj_rd_idx),
    .rd_obj   (obj_rd_data)
  );

endmodule

`default_nettype wire

//--- tb_scene_loader.sv
`timescale 1ns/10ps
`default_nettype none

module tb_scene_loader;
  import scene_pkg::*;

  localparam int CLKS_PER_BIT = 8;
  localparam int NUM_OBJS     = 8;
  localparam int NUM_ENTRIES  = 10;
  localparam int ACK_TIMEOUT  = 20;
  localparam int BUSY_TIMEOUT = 4 * CLKS_PER_BIT;

  typedef enum logic {KIND_CAM, KIND_OBJ} entry_kind_e;

  typedef struct packed {
    entry_kind_e kind;
    logic [7:0]  cmd;
    cam_vec_t    cam;
    scene_obj_t  obj;
  } entry_t;

  logic clk;
  logic rst;
  logic uart_rx;
  logic load_busy;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [6:0] wb_adr;
  logic [31:0] wb_dat_o;
  logic wb_ack;

  logic [31:0] rng_state;
  logic [7:0] cmd_list [NUM_ENTRIES];
  entry_t stim [NUM_ENTRIES];
  cam_vec_t exp_cam [4];           // Reference model of the stores
  scene_obj_t exp_obj [NUM_OBJS];
  logic [31:0] scratch;

  scene_loader_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .NUM_OBJS    (NUM_OBJS)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .uart_rx  (uart_rx),
    .load_busy(load_busy),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_cam(input cam_vec_t got, input cam_vec_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_obj(input scene_obj_t got, input scene_obj_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Start bit, 8 data bits LSB first, stop bit, then one idle bit period
  task automatic send_byte(input logic [7:0] b);
    logic [10:0] frame;
    frame = {2'b11, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic bus_access(input logic we, input logic [6:0] adr, output logic [31:0] data);
    int cycles;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= we;
    wb_adr <= adr;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        $display("Timeout: no Wishbone ack for address %h within %0d cycles", adr, ACK_TIMEOUT);
        abort_run();
      end
    end while (!wb_ack);
    data = wb_dat_o;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);
    check_bit(wb_ack, 1'b0, "wb_ack one cycle after the ack");  // Single-cycle ack
  endtask

  task automatic wait_busy_low();
    int cycles;
    cycles = 0;
    while (load_busy) begin
      @(negedge clk);
      cycles++;
      if (cycles > BUSY_TIMEOUT) begin
        $display("Timeout: load_busy stayed high after the last payload byte");
        abort_run();
      end
    end
  endtask

  // Reads every camera and object word and compares with the model
  task automatic check_scene(input string when);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    for (int v = 0; v < 4; v++) begin
      bus_access(1'b0, 7'(v * 4), w0);
      bus_access(1'b0, 7'(v * 4 + 1), w1);
      bus_access(1'b0, 7'(v * 4 + 2), w2);
      bus_access(1'b0, 7'(v * 4 + 3), w3);
      check_word(w2 & 32'hffff_ff00, 32'd0, $sformatf("camera %0d top padding, %s", v, when));
      check_word(w3, 32'd0, $sformatf("camera %0d word 3, %s", v, when));
      check_cam({w2[7:0], w1, w0}, exp_cam[v], $sformatf("camera %0d, %s", v, when));
    end
    for (int o = 0; o < NUM_OBJS; o++) begin
      bus_access(1'b0, 7'(64 + o * 2), w0);
      bus_access(1'b0, 7'(65 + o * 2), w1);
      check_obj({w1, w0}, exp_obj[o], $sformatf("object %0d, %s", o, when));
    end
  endtask

  task automatic apply_entry(input entry_t e);
    logic [71:0] payload;
    int nbytes;
    if (e.kind == KIND_CAM) begin
      payload = e.cam;
      nbytes  = CAM_BYTES;
    end else begin
      payload = {8'd0, e.obj};
      nbytes  = OBJ_BYTES;
    end
    check_bit(load_busy, 1'b0, "load_busy before command");
    send_byte(e.cmd);
    check_bit(load_busy, 1'b1, "load_busy after command");
    for (int i = 0; i < nbytes; i++) begin
      send_byte(payload[8*i +: 8]);
      if (i < nbytes - 1) check_bit(load_busy, 1'b1, "load_busy between payload bytes");
    end
    wait_busy_low();
    // Model update follows the command encoding
    if (e.kind == KIND_CAM) exp_cam[e.cmd[1:0]] = e.cam;
    else exp_obj[e.cmd[2:0]] = e.obj;
  endtask

  task automatic build_table();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    foreach (stim[i]) begin
      next_rand(r0);
      next_rand(r1);
      next_rand(r2);
      stim[i].cmd  = cmd_list[i];
      stim[i].kind = cmd_list[i][7] ? KIND_CAM : KIND_OBJ;
      stim[i].cam  = {r0[7:0], r1, r2};
      stim[i].obj  = {r1, r2};
    end
  endtask

  initial begin
    rst     = 1'b1;
    uart_rx = 1'b1;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    rng_state = 32'hff72;
    // Index 0x0d and 0x7a wrap to slots 5 and 2, 0xfe hits the forward vector again
    cmd_list = '{8'h80, 8'h00, 8'h81, 8'h03, 8'h82, 8'h07, 8'h83, 8'h0d, 8'h7a, 8'hfe};
    build_table();
    foreach (exp_cam[i]) exp_cam[i] = '0;
    foreach (exp_obj[i]) exp_obj[i] = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit(load_busy, 1'b0, "load_busy after reset");
    check_scene("after reset");
    foreach (stim[i]) begin
      apply_entry(stim[i]);
      check_scene($sformatf("after command %h", stim[i].cmd));
    end
    // Writes are acked and ignored
    bus_access(1'b1, 7'h00, scratch);
    bus_access(1'b1, 7'h06, scratch);
    bus_access(1'b1, 7'h41, scratch);
    bus_access(1'b1, 7'h4a, scratch);
    bus_access(1'b1, 7'h7f, scratch);
    check_scene("after bus writes");
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
scene_pkg.sv
scene_wr_if.sv
uart_byte_rx.sv
scene_cmd_parser.sv
camera_regs.sv
object_ram.sv
scene_wb_port.sv
scene_loader_top.sv
tb_scene_loader.sv

//--- Bender.yml
package:
  name: scene_loader

sources:
  - scene_pkg.sv
  - scene_wr_if.sv
  - uart_byte_rx.sv
  - scene_cmd_parser.sv
  - camera_regs.sv
  - object_ram.sv
  - scene_wb_port.sv
  - scene_loader_top.sv
  - target: simulation
    files:
      - tb_scene_loader.sv
